// ==== src/phy_mgmt_pkg.sv ====
`default_nettype none

package phy_mgmt_pkg;

    ////////////////////
    // widths
    ////////////////////
    typedef logic [15:0] phy_data_t;    // one PHY register value
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  phy_addr_t;
    typedef logic [12:0] ram_addr_t;    // word address into on-chip RAM
    typedef logic [31:0] ram_word_t;

    ////////////////////
    // clause 22 frame fields
    ////////////////////
    localparam logic [3:0] OP_READ  = 4'b0110;  // start 01 + opcode 10
    localparam logic [3:0] OP_WRITE = 4'b0101;  // start 01 + opcode 01
    localparam logic [1:0] TA_WRITE = 2'b10;
    localparam int PREAMBLE_BITS = 32;
    localparam int NUM_PHY_REGS  = 32;

    // format of the dump in RAM
    localparam ram_word_t  RAM_DELIMITER = 32'hAAAA_AAAA;
    localparam logic [3:0] DUMP_TAG      = 4'hB;

    typedef enum logic [2:0] {
        SEQ_WAIT,   // settle time after reset
        SEQ_READ,
        SEQ_DUMP,
        SEQ_WRITE,  // loopback write to reg 0
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        SH_IDLE,
        SH_PREAMBLE,
        SH_CMD,
        SH_TA,
        SH_DATA
    } shift_state_t;

endpackage

`default_nettype wire

// ==== src/mdio_frame_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one MDIO frame request and its result
interface mdio_frame_if;

    logic                    start;     // one cycle pulse
    logic                    is_write;
    phy_mgmt_pkg::reg_addr_t reg_addr;
    phy_mgmt_pkg::phy_data_t wdata;
    logic                    done;      // end of frame
    phy_mgmt_pkg::phy_data_t rdata;     // valid with done

    modport sequencer (output start, is_write, reg_addr, wdata, input done);

    modport shifter (input start, is_write, reg_addr, wdata, output done, rdata);

    // watches finished reads only
    modport capture (input done, is_write, reg_addr, rdata);

endinterface

`default_nettype wire

// ==== src/mdio_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdio_sequencer #(
    parameter int unsigned             POST_RESET_WAIT = 125_000_000,  // board value
    parameter phy_mgmt_pkg::phy_data_t LOOPBACK_VALUE  = 16'h5140
) (
    input  wire                enet_mdc_clk,
    input  wire                CPU_RESETn,
    mdio_frame_if.sequencer    frame,
    output logic               dump_start,
    input  wire                dump_done,
    output logic               scan_done
);

    phy_mgmt_pkg::seq_state_t state;
    logic [31:0]              wait_cnt;
    logic                     second_pass;  // loopback already written

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state          <= phy_mgmt_pkg::SEQ_WAIT;
            wait_cnt       <= '0;
            second_pass    <= 1'b0;
            frame.start    <= 1'b0;
            frame.is_write <= 1'b0;
            frame.reg_addr <= '0;
            dump_start     <= 1'b0;
            scan_done      <= 1'b0;
        end else begin
            frame.start <= 1'b0;
            dump_start  <= 1'b0;

            case (state)
                phy_mgmt_pkg::SEQ_WAIT: begin
                    if (wait_cnt == 32'(POST_RESET_WAIT - 1)) begin
                        frame.start    <= 1'b1;  // first read of reg 0
                        frame.is_write <= 1'b0;
                        frame.reg_addr <= '0;
                        state          <= phy_mgmt_pkg::SEQ_READ;
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end

                phy_mgmt_pkg::SEQ_READ: begin
                    if (frame.done) begin
                        if (frame.reg_addr == 5'(phy_mgmt_pkg::NUM_PHY_REGS - 1)) begin
                            dump_start <= 1'b1;  // whole space captured
                            state      <= phy_mgmt_pkg::SEQ_DUMP;
                        end else begin
                            frame.reg_addr <= frame.reg_addr + 5'd1;
                            frame.start    <= 1'b1;
                        end
                    end
                end

                phy_mgmt_pkg::SEQ_DUMP: begin
                    if (dump_done) begin
                        if (second_pass) begin
                            scan_done <= 1'b1;
                            state     <= phy_mgmt_pkg::SEQ_DONE;
                        end else begin
                            // put the PHY in loopback before the second scan
                            second_pass    <= 1'b1;
                            frame.start    <= 1'b1;
                            frame.is_write <= 1'b1;
                            frame.reg_addr <= '0;
                            frame.wdata    <= LOOPBACK_VALUE;
                            state          <= phy_mgmt_pkg::SEQ_WRITE;
                        end
                    end
                end

                phy_mgmt_pkg::SEQ_WRITE: begin
                    if (frame.done) begin
                        frame.start    <= 1'b1;
                        frame.is_write <= 1'b0;
                        frame.reg_addr <= '0;
                        state          <= phy_mgmt_pkg::SEQ_READ;
                    end
                end

                phy_mgmt_pkg::SEQ_DONE: ;  // hold scan_done

                default: state <= phy_mgmt_pkg::SEQ_WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/mdio_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdio_shifter #(
    parameter phy_mgmt_pkg::phy_addr_t PHY_ADDR = 5'd0
) (
    input  wire          enet_mdc_clk,
    input  wire          CPU_RESETn,
    mdio_frame_if.shifter frame,
    input  wire          mdio_in,
    output logic         mdio_out,
    output logic         mdio_oe
);

    phy_mgmt_pkg::shift_state_t state;
    logic [4:0]              pre_cnt;
    logic [3:0]              cmd_cnt;
    logic                    ta_cnt;
    logic [3:0]              data_cnt;
    logic [15:0]             cmd_word;
    logic [3:0]              cmd_last;
    phy_mgmt_pkg::phy_data_t tx_sr;     // next bits to drive
    phy_mgmt_pkg::phy_data_t rx_sr;

    // a read sends only the top 14 bits, the PHY owns its turnaround
    assign cmd_word = frame.is_write ?
        {phy_mgmt_pkg::OP_WRITE, PHY_ADDR, frame.reg_addr, phy_mgmt_pkg::TA_WRITE} :
        {phy_mgmt_pkg::OP_READ, PHY_ADDR, frame.reg_addr, 2'b00};
    assign cmd_last    = frame.is_write ? 4'd15 : 4'd13;
    assign frame.rdata = rx_sr;

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state      <= phy_mgmt_pkg::SH_IDLE;
            pre_cnt    <= '0;
            cmd_cnt    <= '0;
            ta_cnt     <= 1'b0;
            data_cnt   <= '0;
            mdio_out   <= 1'b1;  // idle high like the pull-up
            mdio_oe    <= 1'b0;
            frame.done <= 1'b0;
        end else begin
            frame.done <= 1'b0;
            case (state)
                phy_mgmt_pkg::SH_IDLE: begin
                    if (frame.start) begin
                        pre_cnt  <= '0;
                        mdio_out <= 1'b1;
                        mdio_oe  <= 1'b1;
                        state    <= phy_mgmt_pkg::SH_PREAMBLE;
                    end
                end
                phy_mgmt_pkg::SH_PREAMBLE: begin
                    if (pre_cnt == 5'(phy_mgmt_pkg::PREAMBLE_BITS - 1)) begin
                        cmd_cnt  <= '0;
                        mdio_out <= cmd_word[15];
                        tx_sr    <= {cmd_word[14:0], 1'b0};
                        state    <= phy_mgmt_pkg::SH_CMD;
                    end else begin
                        pre_cnt <= pre_cnt + 5'd1;
                    end
                end
                phy_mgmt_pkg::SH_CMD: begin
                    if (cmd_cnt == cmd_last) begin
                        data_cnt <= '0;
                        if (frame.is_write) begin
                            mdio_out <= frame.wdata[15];
                            tx_sr    <= {frame.wdata[14:0], 1'b0};
                            state    <= phy_mgmt_pkg::SH_DATA;
                        end else begin
                            ta_cnt   <= 1'b0;
                            mdio_oe  <= 1'b0;  // release the line
                            mdio_out <= 1'b1;
                            state    <= phy_mgmt_pkg::SH_TA;
                        end
                    end else begin
                        cmd_cnt  <= cmd_cnt + 4'd1;
                        mdio_out <= tx_sr[15];
                        tx_sr    <= {tx_sr[14:0], 1'b0};
                    end
                end
                phy_mgmt_pkg::SH_TA: begin
                    if (ta_cnt) state <= phy_mgmt_pkg::SH_DATA;
                    else        ta_cnt <= 1'b1;
                end
                phy_mgmt_pkg::SH_DATA: begin
                    if (frame.is_write) begin
                        mdio_out <= tx_sr[15];
                        tx_sr    <= {tx_sr[14:0], 1'b0};
                    end else begin
                        rx_sr <= {rx_sr[14:0], mdio_in};  // msb first
                    end
                    if (data_cnt == 4'd15) begin
                        frame.done <= 1'b1;
                        mdio_oe    <= 1'b0;
                        mdio_out   <= 1'b1;
                        state      <= phy_mgmt_pkg::SH_IDLE;
                    end else begin
                        data_cnt <= data_cnt + 4'd1;
                    end
                end
                default: state <= phy_mgmt_pkg::SH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_dump_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_dump_writer #(
    parameter phy_mgmt_pkg::ram_addr_t RAM_BASE = 13'h400
) (
    input  wire                      enet_mdc_clk,
    input  wire                      CPU_RESETn,
    mdio_frame_if.capture            frame,
    input  wire                      dump_start,
    output logic                     dump_done,
    output logic                     ram_we,
    output phy_mgmt_pkg::ram_addr_t  ram_addr,
    output phy_mgmt_pkg::ram_word_t  ram_wdata
);

    localparam int DUMP_WORDS = phy_mgmt_pkg::NUM_PHY_REGS + 2;  // plus two delimiters

    phy_mgmt_pkg::phy_data_t bank [phy_mgmt_pkg::NUM_PHY_REGS];
    logic [5:0]              word_cnt;  // next word of the dump
    logic                    active;
    phy_mgmt_pkg::ram_addr_t wr_addr;
    phy_mgmt_pkg::reg_addr_t dump_reg;
    phy_mgmt_pkg::ram_word_t dump_word;

    ////////////////////
    // register bank
    ////////////////////
    always_ff @(posedge enet_mdc_clk) begin
        if (frame.done && !frame.is_write) bank[frame.reg_addr] <= frame.rdata;
    end

    // word 1 holds reg 0, the last word closes the dump
    assign dump_reg  = phy_mgmt_pkg::reg_addr_t'(word_cnt - 6'd1);
    assign dump_word = (word_cnt == 6'(DUMP_WORDS - 1)) ? phy_mgmt_pkg::RAM_DELIMITER :
                       {phy_mgmt_pkg::DUMP_TAG, 3'b000, dump_reg, 4'h0, bank[dump_reg]};

    ////////////////////
    // RAM write port
    ////////////////////
    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            active    <= 1'b0;
            word_cnt  <= '0;
            wr_addr   <= RAM_BASE;
            ram_we    <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            ram_we    <= 1'b0;
            dump_done <= 1'b0;
            if (dump_start) begin
                // opening delimiter goes out right away
                active    <= 1'b1;
                word_cnt  <= 6'd1;
                ram_we    <= 1'b1;
                ram_addr  <= wr_addr;
                ram_wdata <= phy_mgmt_pkg::RAM_DELIMITER;
                wr_addr   <= wr_addr + 13'd1;
            end else if (active) begin
                if (word_cnt == 6'(DUMP_WORDS)) begin
                    active    <= 1'b0;
                    dump_done <= 1'b1;
                end else begin
                    ram_we    <= 1'b1;
                    ram_addr  <= wr_addr;
                    ram_wdata <= dump_word;
                    wr_addr   <= wr_addr + 13'd1;  // keeps going into pass 2
                    word_cnt  <= word_cnt + 6'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/phy_mgmt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_mgmt_top #(
    parameter int unsigned             POST_RESET_WAIT = 12,      // sim value
    parameter phy_mgmt_pkg::phy_addr_t PHY_ADDR        = 5'd0,
    parameter phy_mgmt_pkg::phy_data_t LOOPBACK_VALUE  = 16'h5140, // reg 0 bit 14 set
    parameter phy_mgmt_pkg::ram_addr_t RAM_BASE        = 13'h400
) (
    input  wire                      enet_mdc_clk,
    input  wire                      CPU_RESETn,
    input  wire                      mdio_in,
    output logic                     mdio_out,
    output logic                     mdio_oe,    // pad tristate enable
    output logic                     ram_we,
    output phy_mgmt_pkg::ram_addr_t  ram_addr,
    output phy_mgmt_pkg::ram_word_t  ram_wdata,
    output logic                     scan_done
);

    logic dump_start;
    logic dump_done;

    mdio_frame_if frame ();

    // decode
    mdio_sequencer #(
        .POST_RESET_WAIT (POST_RESET_WAIT),
        .LOOPBACK_VALUE  (LOOPBACK_VALUE)
    ) u_sequencer (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .frame        (frame.sequencer),
        .dump_start   (dump_start),
        .dump_done    (dump_done),
        .scan_done    (scan_done)
    );

    // execute
    mdio_shifter #(
        .PHY_ADDR (PHY_ADDR)
    ) u_shifter (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .frame        (frame.shifter),
        .mdio_in      (mdio_in),
        .mdio_out     (mdio_out),
        .mdio_oe      (mdio_oe)
    );

    // result
    reg_dump_writer #(
        .RAM_BASE (RAM_BASE)
    ) u_writer (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .frame        (frame.capture),
        .dump_start   (dump_start),
        .dump_done    (dump_done),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_phy_mgmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_phy_mgmt;

    localparam string       TRACE_FILE = "tb/phy_reg_trace.txt";
    localparam int          WAIT_LIMIT = 200;      // cycles allowed per wait loop
    localparam logic [4:0]  PHY_ADDR   = 5'd0;
    localparam logic [12:0] RAM_BASE   = 13'h400;
    localparam logic [31:0] DELIMITER  = 32'hAAAA_AAAA;

    logic        enet_mdc_clk;
    logic        CPU_RESETn;
    logic        mdio_in;
    wire         mdio_out;
    wire         mdio_oe;
    wire         ram_we;
    wire  [12:0] ram_addr;
    wire  [31:0] ram_wdata;
    wire         scan_done;

    logic [15:0] trace [0:32];      // 32 register values, then the loopback value
    logic [15:0] phy_regs [0:31];   // the modelled PHY's register file
    logic [12:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    int          wr_cycle_q [$];
    int          cycle;
    int          checks;
    int          mismatches;
    int          problems;          // timeouts and unreadable trace
    bit          hung;

    phy_mgmt_top dut (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .mdio_in      (mdio_in),
        .mdio_out     (mdio_out),
        .mdio_oe      (mdio_oe),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .scan_done    (scan_done)
    );

    initial enet_mdc_clk = 1'b0;
    always #2 enet_mdc_clk = ~enet_mdc_clk;

    always @(posedge enet_mdc_clk) cycle <= cycle + 1;

    // RAM monitor samples at mid cycle
    always @(negedge enet_mdc_clk) begin
        if (ram_we === 1'b1) begin
            wr_addr_q.push_back(ram_addr);
            wr_data_q.push_back(ram_wdata);
            wr_cycle_q.push_back(cycle);
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge enet_mdc_clk);
        #0.5;  // outputs have settled and inputs change here
    endtask

    task automatic report_timeout(input string what);
        problems++;
        hung = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic check_idle_levels();
        check_value("mdio_oe", 32'd0, 32'(mdio_oe));
        check_value("mdio_out", 32'd1, 32'(mdio_out));
        check_value("ram_we", 32'd0, 32'(ram_we));
        check_value("scan_done", 32'd0, 32'(scan_done));
    endtask

    // acts as the PHY for one frame and checks its bits
    task automatic serve_frame(input bit exp_write, input logic [4:0] exp_reg,
                               input string tag);
        int          n;
        int          i;
        int          ones;
        int          oe_high;
        logic [13:0] cmd;
        logic [17:0] tail;  // turnaround and data bits
        logic [15:0] rd_value;
        n = 0;
        do begin
            next_cycle();
            mdio_in = 1'b1;  // pull-up level between frames
            n++;
        end while (mdio_oe !== 1'b1 && n < WAIT_LIMIT);
        if (mdio_oe !== 1'b1) begin
            report_timeout({tag, " frame start"});
            return;
        end
        ones = 0;
        for (i = 0; i < 32; i++) begin
            if (i > 0) next_cycle();
            if (mdio_out === 1'b1 && mdio_oe === 1'b1) ones++;
        end
        check_value({tag, " preamble ones"}, 32'd32, 32'(ones));
        cmd = '0;
        oe_high = 0;
        for (i = 0; i < 14; i++) begin
            next_cycle();
            cmd = {cmd[12:0], mdio_out};
            if (mdio_oe === 1'b1) oe_high++;
        end
        check_value({tag, " opcode"}, exp_write ? 32'h5 : 32'h6, 32'(cmd[13:10]));
        check_value({tag, " phy addr"}, 32'(PHY_ADDR), 32'(cmd[9:5]));
        check_value({tag, " reg addr"}, 32'(exp_reg), 32'(cmd[4:0]));
        check_value({tag, " mdio_oe in command"}, 32'd14, 32'(oe_high));
        rd_value = phy_regs[cmd[4:0]];
        tail = '0;
        oe_high = 0;
        for (i = 0; i < 18; i++) begin
            next_cycle();
            if (!exp_write && i >= 2) mdio_in = rd_value[17 - i];  // msb first
            tail = {tail[16:0], mdio_out};
            if (mdio_oe === 1'b1) oe_high++;
        end
        if (exp_write) begin
            check_value({tag, " turnaround"}, 32'h2, 32'(tail[17:16]));
            check_value({tag, " write data"}, 32'(trace[32]), 32'(tail[15:0]));
            check_value({tag, " mdio_oe in data"}, 32'd18, 32'(oe_high));
            phy_regs[cmd[4:0]] = tail[15:0];
        end else begin
            check_value({tag, " mdio_oe in data"}, 32'd0, 32'(oe_high));
        end
    endtask

    task automatic wait_words(input int count, input string what);
        int n;
        n = 0;
        while (wr_data_q.size() < count && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (wr_data_q.size() < count) report_timeout(what);
    endtask

    // 34 words from index first; looped means reg 0 holds the loopback value
    task automatic check_dump(input int first, input logic [12:0] base, input bit looped);
        int          i;
        logic [31:0] exp_word;
        logic [15:0] value;
        for (i = 0; i < 34; i++) begin
            if (i == 0 || i == 33) begin
                exp_word = DELIMITER;
            end else begin
                value    = (looped && i == 1) ? trace[32] : trace[i - 1];
                exp_word = {4'hB, 3'b000, 5'(i - 1), 4'h0, value};
            end
            check_value($sformatf("ram_addr[%0d]", first + i), 32'(base + 13'(i)),
                        32'(wr_addr_q[first + i]));
            check_value($sformatf("ram_wdata[%0d]", first + i), exp_word,
                        wr_data_q[first + i]);
            if (i > 0) begin
                // each word follows the one before it by one cycle
                check_value($sformatf("ram_we cycle[%0d]", first + i),
                            wr_cycle_q[first + i - 1] + 1, wr_cycle_q[first + i]);
            end
        end
    endtask

    task automatic end_test(input int num, input string name, input int mark);
        int fails;
        fails = mismatches + problems - mark;
        if (fails == 0) $display("test %0d %s: ok", num, name);
        else            $display("test %0d %s: %0d errors", num, name, fails);
    endtask

    ////////////////////
    // sequence
    ////////////////////
    initial begin
        int i;
        int n;
        int mark;
        CPU_RESETn = 1'b0;
        mdio_in    = 1'b1;
        cycle      = 0;
        checks     = 0;
        mismatches = 0;
        problems   = 0;
        hung       = 1'b0;
        $readmemh(TRACE_FILE, trace);
        for (i = 0; i < 32; i++) phy_regs[i] = trace[i];
        if ($isunknown(trace[32]) || trace[32] == 16'h0000) begin
            problems++;
            $display("trace file %s is missing or incomplete", TRACE_FILE);
        end

        mark = mismatches + problems;
        for (i = 0; i < 5; i++) begin
            next_cycle();
            check_idle_levels();
        end
        CPU_RESETn = 1'b1;
        for (i = 0; i < 4; i++) begin
            next_cycle();
            check_idle_levels();  // still in the settle wait
        end
        end_test(1, "reset levels", mark);

        mark = mismatches + problems;
        for (i = 0; i < 32; i++) begin
            if (!hung) serve_frame(1'b0, 5'(i), $sformatf("pass 1 read %0d", i));
        end
        end_test(2, "first read pass", mark);

        mark = mismatches + problems;
        if (!hung) wait_words(34, "first dump");
        if (!hung) check_dump(0, RAM_BASE, 1'b0);
        end_test(3, "first dump", mark);

        mark = mismatches + problems;
        if (!hung) serve_frame(1'b1, 5'd0, "loopback write");
        end_test(4, "loopback write", mark);

        mark = mismatches + problems;
        for (i = 0; i < 32; i++) begin
            if (!hung) serve_frame(1'b0, 5'(i), $sformatf("pass 2 read %0d", i));
        end
        if (!hung) wait_words(68, "second dump");
        if (!hung) check_dump(34, RAM_BASE + 13'd34, 1'b1);
        n = 0;
        while (!hung && scan_done !== 1'b1 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!hung && scan_done !== 1'b1) report_timeout("scan_done");
        if (!hung) begin
            for (i = 0; i < 20; i++) next_cycle();
            check_value("ram_we word count", 32'd68, 32'(wr_data_q.size()));
            check_value("scan_done held", 32'd1, 32'(scan_done));
        end
        end_test(5, "second pass and done", mark);

        $display("checks run %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, problems);
        if (mismatches == 0 && problems == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/phy_reg_trace.txt ====
// PHY register values for registers 0 to 31, one hex word per line
// last line is the loopback value the DUT writes to register 0
1140
796d
0141
0cc2
01e1
c1e1
000d
2001
4d28
0300
7c00
0000
0000
0000
0000
3000
0078
8100
a0f2
0c60
0000
0000
0000
0000
0a1b
5c3e
0f00
848b
c004
0002
1f33
6e07
5140

// ==== project.f ====
src/phy_mgmt_pkg.sv
src/mdio_frame_if.sv
src/mdio_sequencer.sv
src/mdio_shifter.sv
src/reg_dump_writer.sv
src/phy_mgmt_top.sv
tb/tb_phy_mgmt.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_phy_mgmt -f project.f -o tb_phy_mgmt_sim
out=$(./obj_dir/tb_phy_mgmt_sim)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
